// File: compile.f
logic/RvTypes.sv
logic/InstDecoder.sv
logic/DatapathController.sv
logic/StallController.sv
logic/ForwardController.sv
logic/RegisterFile.sv
logic/BranchUnit.sv
logic/StageID.sv
test/StageIDTb.sv

// File: logic/BranchUnit.sv
`timescale 1ns/1ps

module BranchUnit (
    input  RvTypes::BranchOp i_branchOp,
    input  RvTypes::InstAddr i_pc,
    input  RvTypes::Data     i_imm,
    input  RvTypes::Data     i_dataA,       // Forwarded rs1
    input  RvTypes::Data     i_dataB,       // Forwarded rs2
    output RvTypes::InstAddr o_pcNext);

    import RvTypes::*;

    logic taken;

    always_comb begin
        case (i_branchOp)
            BR_BEQ:  taken = (i_dataA == i_dataB);
            BR_BNE:  taken = (i_dataA != i_dataB);
            BR_BLT:  taken = ($signed(i_dataA) < $signed(i_dataB));
            BR_BGE:  taken = ($signed(i_dataA) >= $signed(i_dataB));
            BR_BLTU: taken = (i_dataA < i_dataB);
            BR_BGEU: taken = (i_dataA >= i_dataB);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;          // None, JALR handled below
        endcase
    end

    always_comb begin
        if (i_branchOp == BR_JALR) begin
            o_pcNext = (i_dataA + i_imm) & ~InstAddr'(1);   // Bit 0 cleared
        end else if (taken) begin
            o_pcNext = i_pc + i_imm;
        end else begin
            o_pcNext = i_pc + InstAddr'(4);                 // Sequential
        end
    end

endmodule

// File: logic/DatapathController.sv
`timescale 1ns/1ps

module DatapathController (
    input  RvTypes::OpCode      i_opCode,
    input  logic [2:0]          i_funct3,
    input  logic                i_funct7b5,
    input  logic                i_isIllegal,        // Kills all side effects
    output RvTypes::AluOp       o_aluControl,
    output logic                o_regWrEnable,
    output logic                o_memWrEnable,
    output logic                o_memRdEnable,
    output RvTypes::DataAccess  o_memAccess,
    output logic                o_memUnsigned,      // LBU and LHU
    output RvTypes::WrDataSel   o_regWrDataSel,
    output RvTypes::OperandASel o_operandASel,
    output RvTypes::OperandBSel o_operandBSel,
    output RvTypes::BranchOp    o_branchOp);

    import RvTypes::*;

    AluOp    aluFunct;      // ALU op from funct3
    BranchOp branchCond;    // Compare kind from funct3
    BranchOp branch;
    logic    regWr;
    logic    memWr;
    logic    memRd;

    always_comb begin
        case (i_funct3)
            3'b000:  aluFunct = (i_opCode == OPC_OP && i_funct7b5) ? ALU_SUB : ALU_ADD;
            3'b001:  aluFunct = ALU_SLL;
            3'b010:  aluFunct = ALU_SLT;
            3'b011:  aluFunct = ALU_SLTU;
            3'b100:  aluFunct = ALU_XOR;
            3'b101:  aluFunct = i_funct7b5 ? ALU_SRA : ALU_SRL;   // Also SRAI
            3'b110:  aluFunct = ALU_OR;
            default: aluFunct = ALU_AND;
        endcase
        case (i_funct3)
            3'b000:  branchCond = BR_BEQ;
            3'b001:  branchCond = BR_BNE;
            3'b100:  branchCond = BR_BLT;
            3'b101:  branchCond = BR_BGE;
            3'b110:  branchCond = BR_BLTU;
            3'b111:  branchCond = BR_BGEU;
            default: branchCond = BR_NONE;    // Reserved encodings fall through
        endcase
    end

    always_comb begin
        o_aluControl   = ALU_ADD;
        o_memAccess    = ACCESS_WORD;
        o_memUnsigned  = 1'b0;
        o_regWrDataSel = WR_ALU;
        o_operandASel  = OPA_REG;
        o_operandBSel  = OPB_IMM;
        regWr          = 1'b0;
        memWr          = 1'b0;
        memRd          = 1'b0;
        branch         = BR_NONE;
        case (i_opCode)
            OPC_LOAD, OPC_STORE: begin                    // Address is rs1 + imm
                o_memAccess   = DataAccess'(i_funct3[1:0]);
                o_memUnsigned = i_funct3[2];
                regWr         = (i_opCode == OPC_LOAD);
                memRd         = (i_opCode == OPC_LOAD);
                memWr         = (i_opCode == OPC_STORE);
                if (i_opCode == OPC_LOAD) o_regWrDataSel = WR_MEM;
            end
            OPC_BRANCH: begin
                o_operandBSel = OPB_REG;
                branch        = branchCond;
            end
            OPC_JAL, OPC_JALR: begin                      // Link value is PC + 4
                regWr          = 1'b1;
                o_regWrDataSel = WR_PC4;
                o_operandASel  = OPA_PC;
                o_operandBSel  = OPB_FOUR;
                branch         = (i_opCode == OPC_JAL) ? BR_JAL : BR_JALR;
            end
            OPC_OP_IMM, OPC_OP: begin
                regWr         = 1'b1;
                o_aluControl  = aluFunct;
                o_operandBSel = (i_opCode == OPC_OP) ? OPB_REG : OPB_IMM;
            end
            OPC_LUI: begin
                regWr          = 1'b1;
                o_regWrDataSel = WR_IMM;
                o_operandASel  = OPA_ZERO;
            end
            OPC_AUIPC: begin
                regWr         = 1'b1;
                o_operandASel = OPA_PC;
            end
            default: ;                                    // SYSTEM and unknown do nothing
        endcase
    end

    assign o_regWrEnable = regWr && !i_isIllegal;
    assign o_memWrEnable = memWr && !i_isIllegal;
    assign o_memRdEnable = memRd && !i_isIllegal;
    assign o_branchOp    = i_isIllegal ? BR_NONE : branch;

    // One memory direction per instruction
    assert property (@(i_opCode) !$isunknown(i_opCode) |-> !(o_memRdEnable && o_memWrEnable))
        else $error("DatapathController: memory read and write both enabled");

endmodule

// File: logic/ForwardController.sv
`timescale 1ns/1ps

module ForwardController (
    input  RvTypes::RegAddr   i_rs1,
    input  RvTypes::RegAddr   i_rs2,
    input  RvTypes::Data      i_regDataA,       // Register file port A
    input  RvTypes::Data      i_regDataB,       // Register file port B
    input  RvTypes::RegAddr   i_exRegWrAddr,
    input  logic              i_exRegWrEnable,
    input  RvTypes::WrDataSel i_exRegWrDataSel,
    input  RvTypes::Data      i_exRegWrData,
    input  RvTypes::RegAddr   i_memRegWrAddr,
    input  logic              i_memRegWrEnable,
    input  RvTypes::Data      i_memRegWrData,
    input  RvTypes::RegAddr   i_wbRegWrAddr,
    input  logic              i_wbRegWrEnable,
    input  RvTypes::Data      i_wbRegWrData,
    output RvTypes::Data      o_dataA,
    output RvTypes::Data      o_dataB);

    import RvTypes::*;

    logic exValid;
    logic memValid;
    logic wbValid;

    // EX load data does not exist yet
    assign exValid  = i_exRegWrEnable && (i_exRegWrDataSel != WR_MEM) && (i_exRegWrAddr != '0);
    assign memValid = i_memRegWrEnable && (i_memRegWrAddr != '0);
    assign wbValid  = i_wbRegWrEnable && (i_wbRegWrAddr != '0);

    // Youngest result wins
    function automatic Data selectOperand(input RegAddr rs, input Data regData);
        return (rs == '0)                         ? '0 :
               (exValid  && i_exRegWrAddr  == rs) ? i_exRegWrData :
               (memValid && i_memRegWrAddr == rs) ? i_memRegWrData :
               (wbValid  && i_wbRegWrAddr  == rs) ? i_wbRegWrData : regData;
    endfunction

    always_comb begin
        o_dataA = selectOperand(i_rs1, i_regDataA);
        o_dataB = selectOperand(i_rs2, i_regDataB);
    end

endmodule

// File: logic/InstDecoder.sv
`timescale 1ns/1ps

module InstDecoder (
    input  RvTypes::Inst    i_inst,         // Instruction word
    output RvTypes::OpCode  o_opCode,       // Major opcode
    output logic [2:0]      o_funct3,
    output logic            o_funct7b5,     // Bit 30, SUB and SRA select
    output RvTypes::RegAddr o_rs1,
    output RvTypes::RegAddr o_rs2,
    output RvTypes::RegAddr o_rd,
    output RvTypes::Data    o_imm,          // Sign-extended immediate
    output logic            o_isLoad,
    output logic            o_isIllegal);

    import RvTypes::*;

    Data immI;
    Data immS;
    Data immB;
    Data immU;
    Data immJ;

    assign o_opCode   = OpCode'(i_inst[6:0]);
    assign o_funct3   = i_inst[14:12];
    assign o_funct7b5 = i_inst[30];
    assign o_rs1      = i_inst[19:15];
    assign o_rs2      = i_inst[24:20];
    assign o_rd       = i_inst[11:7];
    assign o_isLoad   = (o_opCode == OPC_LOAD);

    // One immediate per format, all signed from bit 31
    assign immI = {{20{i_inst[31]}}, i_inst[31:20]};
    assign immS = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign immB = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign immU = {i_inst[31:12], 12'b0};
    assign immJ = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    always_comb begin
        o_isIllegal = 1'b0;
        case (o_opCode)
            OPC_LOAD, OPC_JALR, OPC_OP_IMM: o_imm = immI;
            OPC_STORE:                      o_imm = immS;
            OPC_BRANCH:                     o_imm = immB;
            OPC_LUI, OPC_AUIPC:             o_imm = immU;
            OPC_JAL:                        o_imm = immJ;
            OPC_OP:                         o_imm = '0;     // R-type, no immediate
            default: begin                                  // SYSTEM or undefined
                o_imm       = '0;
                o_isIllegal = 1'b1;
            end
        endcase
    end

    // Loads must never reach the illegal path
    assert property (@(i_inst) !$isunknown(i_inst) |-> !(o_isLoad && o_isIllegal))
        else $error("InstDecoder: load decoded as illegal");

endmodule

// File: logic/RegisterFile.sv
`timescale 1ns/1ps

module RegisterFile (
    input  logic            i_clock,
    input  logic            i_rst,
    input  logic            i_wrEnable,
    input  RvTypes::RegAddr i_wrAddr,
    input  RvTypes::Data    i_wrData,
    input  RvTypes::RegAddr i_rdAddrA,
    input  RvTypes::RegAddr i_rdAddrB,
    output RvTypes::Data    o_rdDataA,
    output RvTypes::Data    o_rdDataB);

    import RvTypes::*;

    Data regs [1:REG_COUNT-1];      // Only x1 to x31 as x0 is constant

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wrEnable && i_wrAddr != '0) begin
            regs[i_wrAddr] <= i_wrData;             // WB write
        end
    end

    assign o_rdDataA = (i_rdAddrA == '0) ? '0 : regs[i_rdAddrA];
    assign o_rdDataB = (i_rdAddrB == '0) ? '0 : regs[i_rdAddrB];

endmodule

// File: logic/RvTypes.sv
package RvTypes;

    localparam int XLEN       = 32;     // Data path width
    localparam int REG_ADDR_W = 5;      // Register index width
    localparam int REG_COUNT  = 32;     // Architectural registers

    typedef logic [XLEN-1:0]       Data;
    typedef logic [31:0]           Inst;
    typedef logic [XLEN-1:0]       InstAddr;
    typedef logic [REG_ADDR_W-1:0] RegAddr;

    localparam Inst NOP_INST = 32'h0000_0013;   // addi x0, x0, 0

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011
    } OpCode;

    // Same bits as {funct7[5], funct3} of the R-type form
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } AluOp;

    typedef enum logic [1:0] {ACCESS_BYTE, ACCESS_HALF, ACCESS_WORD} DataAccess; // funct3[1:0]
    typedef enum logic [1:0] {WR_ALU, WR_MEM, WR_PC4, WR_IMM} WrDataSel;
    typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} OperandASel;
    typedef enum logic [1:0] {OPB_REG, OPB_IMM, OPB_FOUR} OperandBSel;
    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } BranchOp;

endpackage

// File: logic/StageID.sv
`timescale 1ns/1ps

module StageID (
    input  logic                i_clock,
    input  logic                i_rst,
    input  RvTypes::Inst        i_inst,
    input  RvTypes::InstAddr    i_pc,
    input  RvTypes::RegAddr     i_exRegWrAddr,
    input  logic                i_exRegWrEnable,
    input  RvTypes::WrDataSel   i_exRegWrDataSel,
    input  RvTypes::Data        i_exRegWrData,
    input  logic                i_exIsLoad,
    input  RvTypes::RegAddr     i_memRegWrAddr,
    input  logic                i_memRegWrEnable,
    input  RvTypes::Data        i_memRegWrData,
    input  logic                i_memIsLoad,
    input  RvTypes::RegAddr     i_wbRegWrAddr,
    input  logic                i_wbRegWrEnable,
    input  RvTypes::Data        i_wbRegWrData,
    output RvTypes::Data        o_instImm,
    output RvTypes::Data        o_dataA,            // Forwarded rs1
    output RvTypes::Data        o_dataB,            // Forwarded rs2
    output logic                o_isLoad,
    output logic                o_bubble,           // Load-use stall request
    output RvTypes::RegAddr     o_regWrAddr,
    output logic                o_regWrEnable,
    output logic                o_memWrEnable,
    output logic                o_memRdEnable,
    output RvTypes::DataAccess  o_memAccess,
    output logic                o_memUnsigned,
    output RvTypes::WrDataSel   o_regWrDataSel,
    output RvTypes::OperandASel o_operandASel,
    output RvTypes::OperandBSel o_operandBSel,
    output RvTypes::AluOp       o_aluControl,
    output RvTypes::InstAddr    o_pcNext);

    import RvTypes::*;

    OpCode      decOpCode;
    logic [2:0] decFunct3;
    logic       decFunct7b5;
    RegAddr     decRs1;
    RegAddr     decRs2;
    logic       decIsIllegal;
    Data        regDataA;       // Raw register file reads
    Data        regDataB;
    BranchOp    dpBranchOp;

    // ----------------------------------------------------------------------
    // Decode and control
    // ----------------------------------------------------------------------

    InstDecoder dec (
        .i_inst      (i_inst),
        .o_opCode    (decOpCode),
        .o_funct3    (decFunct3),
        .o_funct7b5  (decFunct7b5),
        .o_rs1       (decRs1),
        .o_rs2       (decRs2),
        .o_rd        (o_regWrAddr),
        .o_imm       (o_instImm),
        .o_isLoad    (o_isLoad),
        .o_isIllegal (decIsIllegal));

    DatapathController dpCtrl (
        .i_opCode       (decOpCode),
        .i_funct3       (decFunct3),
        .i_funct7b5     (decFunct7b5),
        .i_isIllegal    (decIsIllegal),
        .o_aluControl   (o_aluControl),
        .o_regWrEnable  (o_regWrEnable),
        .o_memWrEnable  (o_memWrEnable),
        .o_memRdEnable  (o_memRdEnable),
        .o_memAccess    (o_memAccess),
        .o_memUnsigned  (o_memUnsigned),
        .o_regWrDataSel (o_regWrDataSel),
        .o_operandASel  (o_operandASel),
        .o_operandBSel  (o_operandBSel),
        .o_branchOp     (dpBranchOp));

    StallController stallCtrl (
        .i_rs1          (decRs1),
        .i_rs2          (decRs2),
        .i_exIsLoad     (i_exIsLoad),
        .i_exRegWrAddr  (i_exRegWrAddr),
        .i_memIsLoad    (i_memIsLoad),
        .i_memRegWrAddr (i_memRegWrAddr),
        .o_bubble       (o_bubble));

    // ----------------------------------------------------------------------
    // Operands
    // ----------------------------------------------------------------------

    RegisterFile regs (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_wrEnable (i_wbRegWrEnable),      // WB owns the write port
        .i_wrAddr   (i_wbRegWrAddr),
        .i_wrData   (i_wbRegWrData),
        .i_rdAddrA  (decRs1),
        .i_rdAddrB  (decRs2),
        .o_rdDataA  (regDataA),
        .o_rdDataB  (regDataB));

    ForwardController fwdCtrl (
        .i_rs1            (decRs1),
        .i_rs2            (decRs2),
        .i_regDataA       (regDataA),
        .i_regDataB       (regDataB),
        .i_exRegWrAddr    (i_exRegWrAddr),
        .i_exRegWrEnable  (i_exRegWrEnable),
        .i_exRegWrDataSel (i_exRegWrDataSel),
        .i_exRegWrData    (i_exRegWrData),
        .i_memRegWrAddr   (i_memRegWrAddr),
        .i_memRegWrEnable (i_memRegWrEnable),
        .i_memRegWrData   (i_memRegWrData),
        .i_wbRegWrAddr    (i_wbRegWrAddr),
        .i_wbRegWrEnable  (i_wbRegWrEnable),
        .i_wbRegWrData    (i_wbRegWrData),
        .o_dataA          (o_dataA),
        .o_dataB          (o_dataB));

    // ----------------------------------------------------------------------
    // Next PC, resolved in ID
    // ----------------------------------------------------------------------

    BranchUnit brUnit (
        .i_branchOp (dpBranchOp),
        .i_pc       (i_pc),
        .i_imm      (o_instImm),
        .i_dataA    (o_dataA),
        .i_dataB    (o_dataB),
        .o_pcNext   (o_pcNext));

endmodule

// File: logic/StallController.sv
`timescale 1ns/1ps

module StallController (
    input  RvTypes::RegAddr i_rs1,
    input  RvTypes::RegAddr i_rs2,
    input  logic            i_exIsLoad,
    input  RvTypes::RegAddr i_exRegWrAddr,
    input  logic            i_memIsLoad,    // Still needed, branches compare in ID
    input  RvTypes::RegAddr i_memRegWrAddr,
    output logic            o_bubble);

    logic exHazard;
    logic memHazard;

    assign exHazard  = i_exIsLoad && (i_exRegWrAddr != '0)
                    && (i_exRegWrAddr == i_rs1 || i_exRegWrAddr == i_rs2);
    assign memHazard = i_memIsLoad && (i_memRegWrAddr != '0)
                    && (i_memRegWrAddr == i_rs1 || i_memRegWrAddr == i_rs2);

    assign o_bubble = exHazard || memHazard;    // Hold ID, insert a NOP into EX

endmodule

// File: test/StageIDTb.sv
`timescale 1ns/1ps

module StageIDTb;

    import RvTypes::*;

    localparam int REG_TRIALS  = 40;        // Write then read pairs
    localparam int RAND_TRIALS = 300;       // Mixed decode, forward, stall, next PC
    localparam int TEST_CYCLES = 5 + 1 + 16 + 2 * REG_TRIALS + RAND_TRIALS + 1;

    logic       i_clock = 1'b0;
    logic       i_rst;
    Inst        i_inst;
    InstAddr    i_pc;
    RegAddr     i_exRegWrAddr, i_memRegWrAddr, i_wbRegWrAddr;
    logic       i_exRegWrEnable, i_memRegWrEnable, i_wbRegWrEnable;
    logic       i_exIsLoad, i_memIsLoad;
    WrDataSel   i_exRegWrDataSel;
    Data        i_exRegWrData, i_memRegWrData, i_wbRegWrData;
    Data        o_instImm, o_dataA, o_dataB;
    logic       o_isLoad, o_bubble, o_regWrEnable, o_memWrEnable, o_memRdEnable;
    logic       o_memUnsigned;
    RegAddr     o_regWrAddr;
    DataAccess  o_memAccess;
    WrDataSel   o_regWrDataSel;
    OperandASel o_operandASel;
    OperandBSel o_operandBSel;
    AluOp       o_aluControl;
    InstAddr    o_pcNext;

    Data         shadow [REG_COUNT];        // Register contents after the last edge
    Data         expA, expB, expImm;
    InstAddr     expPc;
    logic        expBubble;
    logic        immValid;                  // Format has a defined immediate
    logic        memOp;
    logic [2:0]  expMem;                    // {access, unsigned}
    logic [18:0] expCtrl;
    logic [18:0] dutCtrl;
    logic [15:0] lfsr = 16'd75;
    int          errors = 0;
    int          cycles = 0;

    StageID u_StageID (.*);

    always #50 i_clock = ~i_clock;          // 100 ns period

    assign dutCtrl = {o_isLoad, o_regWrAddr, o_regWrEnable, o_memWrEnable, o_memRdEnable,
                      o_regWrDataSel, o_operandASel, o_operandBSel, o_aluControl};

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};  // x^16+x^14+x^13+x^11+1
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic Inst encodeFields(input logic [6:0] f7, input RegAddr rs2,
                                         input RegAddr rs1, input logic [2:0] f3,
                                         input RegAddr rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};     // R layout, other formats reuse the bits
    endfunction

    function automatic logic [6:0] pickOpcode(input logic [3:0] idx);
        case (idx % 12)
            0:       return OPC_LOAD;
            1:       return OPC_STORE;
            2:       return OPC_BRANCH;
            3:       return OPC_JAL;
            4:       return OPC_JALR;
            5:       return OPC_OP_IMM;
            6:       return OPC_OP;
            7:       return OPC_LUI;
            8:       return OPC_AUIPC;
            9:       return OPC_SYSTEM;
            10:      return 7'b0000000;     // Undefined
            default: return 7'b1111111;     // Undefined
        endcase
    endfunction

    task automatic clearStages();
        i_exRegWrAddr    = '0;
        i_exRegWrEnable  = 1'b0;
        i_exRegWrDataSel = WR_ALU;
        i_exRegWrData    = '0;
        i_exIsLoad       = 1'b0;
        i_memRegWrAddr   = '0;
        i_memRegWrEnable = 1'b0;
        i_memRegWrData   = '0;
        i_memIsLoad      = 1'b0;
        i_wbRegWrAddr    = '0;
        i_wbRegWrEnable  = 1'b0;
        i_wbRegWrData    = '0;
    endtask

    task automatic nextCycle();
        @(negedge i_clock);
        if (i_wbRegWrEnable && i_wbRegWrAddr != '0) begin
            shadow[i_wbRegWrAddr] = i_wbRegWrData;      // Landed on the last rising edge
        end
        cycles++;
    endtask

    task automatic randomCycle();
        Inst word;
        word        = randBits(32);
        word[6:0]   = pickOpcode(randBits(4));
        word[19:15] = randBits(2);          // Few registers, so stages collide often
        word[24:20] = randBits(2);
        if (word[6:0] == OPC_OP) begin
            word[31:25] = {1'b0, word[30], 5'b0};       // Only SUB and SRA set bit 30
        end
        i_inst           = word;
        i_pc             = {randBits(30), 2'b00};
        i_exRegWrAddr    = randBits(2);
        i_exRegWrEnable  = randBits(1);
        i_exRegWrDataSel = WrDataSel'(randBits(2));
        i_exRegWrData    = randBits(32);
        i_exIsLoad       = randBits(1);
        i_memRegWrAddr   = randBits(2);
        i_memRegWrEnable = randBits(1);
        i_memRegWrData   = randBits(32);
        i_memIsLoad      = randBits(1);
        i_wbRegWrAddr    = randBits(2);
        i_wbRegWrEnable  = randBits(1);
        i_wbRegWrData    = randBits(32);
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    function automatic Data forwardModel(input RegAddr rs);
        if (rs == '0) return '0;            // x0 never forwarded
        if (i_exRegWrEnable && i_exRegWrDataSel != WR_MEM && i_exRegWrAddr == rs) begin
            return i_exRegWrData;
        end
        if (i_memRegWrEnable && i_memRegWrAddr == rs) return i_memRegWrData;
        if (i_wbRegWrEnable && i_wbRegWrAddr == rs) return i_wbRegWrData;
        return shadow[rs];
    endfunction

    task automatic predict();
        Data        immI, immS, immB, immU, immJ;
        OpCode      opc;
        logic [2:0] f3;
        logic       taken;
        logic       regWr;
        logic       memWr;
        logic       memRd;
        WrDataSel   wrSel;
        OperandASel opA;
        OperandBSel opB;
        AluOp       alu;
        opc  = OpCode'(i_inst[6:0]);
        f3   = i_inst[14:12];
        immI = {{20{i_inst[31]}}, i_inst[31:20]};
        immS = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
        immB = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
        immU = {i_inst[31:12], 12'b0};
        immJ = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
        expA = forwardModel(i_inst[19:15]);
        expB = forwardModel(i_inst[24:20]);
        expBubble = (i_exIsLoad && i_exRegWrAddr != '0 && (i_exRegWrAddr == i_inst[19:15]
                     || i_exRegWrAddr == i_inst[24:20]))
                 || (i_memIsLoad && i_memRegWrAddr != '0 && (i_memRegWrAddr == i_inst[19:15]
                     || i_memRegWrAddr == i_inst[24:20]));
        case (f3)
            3'b000:  taken = (expA == expB);
            3'b001:  taken = (expA != expB);
            3'b100:  taken = ($signed(expA) < $signed(expB));
            3'b101:  taken = ($signed(expA) >= $signed(expB));
            3'b110:  taken = (expA < expB);
            3'b111:  taken = (expA >= expB);
            default: taken = 1'b0;          // Reserved compare never branches
        endcase
        regWr    = 1'b0;
        memWr    = 1'b0;
        memRd    = 1'b0;
        wrSel    = WR_ALU;
        opA      = OPA_REG;
        opB      = OPB_IMM;
        alu      = ALU_ADD;
        memOp    = 1'b0;
        immValid = 1'b1;
        expImm   = immI;
        expPc    = i_pc + 32'd4;
        expMem   = {f3[1:0], f3[2]};        // Size from funct3, bit 2 unsigned
        case (opc)
            OPC_LOAD: begin
                regWr = 1'b1;
                memRd = 1'b1;
                wrSel = WR_MEM;
                memOp = 1'b1;
            end
            OPC_STORE: begin
                memWr  = 1'b1;
                memOp  = 1'b1;
                expImm = immS;
            end
            OPC_BRANCH: begin
                opB    = OPB_REG;
                expImm = immB;
                expPc  = taken ? i_pc + immB : i_pc + 32'd4;
            end
            OPC_JAL, OPC_JALR: begin
                regWr  = 1'b1;
                wrSel  = WR_PC4;            // Link address
                opA    = OPA_PC;
                opB    = OPB_FOUR;
                expImm = (opc == OPC_JAL) ? immJ : immI;
                expPc  = (opc == OPC_JAL) ? i_pc + immJ : (expA + immI) & ~32'd1;
            end
            OPC_OP_IMM, OPC_OP: begin
                regWr  = 1'b1;
                alu    = AluOp'({i_inst[30] && (f3 == 3'b101
                                 || (f3 == 3'b000 && opc == OPC_OP)), f3});
                opB    = (opc == OPC_OP) ? OPB_REG : OPB_IMM;
                expImm = (opc == OPC_OP) ? '0 : immI;
            end
            OPC_LUI, OPC_AUIPC: begin
                regWr  = 1'b1;
                wrSel  = (opc == OPC_LUI) ? WR_IMM : WR_ALU;
                opA    = (opc == OPC_LUI) ? OPA_ZERO : OPA_PC;
                expImm = immU;
            end
            default: immValid = 1'b0;       // SYSTEM and undefined, no side effects
        endcase
        expCtrl = {opc == OPC_LOAD, i_inst[11:7], regWr, memWr, memRd, wrSel, opA, opB, alu};
    endtask

    // ------------------------------------------------------------------
    // Checks, sampled on the rising edge
    // ------------------------------------------------------------------

    task automatic flagMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        errors++;
        $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
    endtask

    assert property (@(posedge i_clock) disable iff (i_rst) o_dataA == expA)
        else flagMismatch("o_dataA", $sampled(expA), $sampled(o_dataA));
    assert property (@(posedge i_clock) disable iff (i_rst) o_dataB == expB)
        else flagMismatch("o_dataB", $sampled(expB), $sampled(o_dataB));
    assert property (@(posedge i_clock) disable iff (i_rst) o_bubble == expBubble)
        else flagMismatch("o_bubble", $sampled(expBubble), $sampled(o_bubble));
    assert property (@(posedge i_clock) disable iff (i_rst) o_pcNext == expPc)
        else flagMismatch("o_pcNext", $sampled(expPc), $sampled(o_pcNext));
    assert property (@(posedge i_clock) disable iff (i_rst) immValid |-> o_instImm == expImm)
        else flagMismatch("o_instImm", $sampled(expImm), $sampled(o_instImm));
    assert property (@(posedge i_clock) disable iff (i_rst) dutCtrl == expCtrl)
        else flagMismatch("control outputs", $sampled(expCtrl), $sampled(dutCtrl));
    assert property (@(posedge i_clock) disable iff (i_rst)
        memOp |-> {o_memAccess, o_memUnsigned} == expMem)
        else flagMismatch("o_memAccess", $sampled(expMem), $sampled({o_memAccess, o_memUnsigned}));

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin
        RegAddr written;
        for (int r = 0; r < REG_COUNT; r++) begin
            shadow[r] = '0;
        end
        i_rst  = 1'b1;
        i_inst = NOP_INST;
        i_pc   = '0;
        clearStages();
        repeat (5) @(posedge i_clock);
        nextCycle();
        i_rst = 1'b0;
        predict();                          // NOP right after reset
        for (int r = 0; r < REG_COUNT; r += 2) begin
            nextCycle();
            i_inst = encodeFields(7'd0, RegAddr'(r + 1), RegAddr'(r), 3'b000, 5'd0, OPC_OP);
            predict();                      // All zero after reset
        end
        for (int t = 0; t < REG_TRIALS; t++) begin
            nextCycle();
            i_inst          = NOP_INST;
            i_wbRegWrEnable = 1'b1;
            i_wbRegWrAddr   = (t == 0) ? RegAddr'(0) : RegAddr'(randBits(5));  // x0 first
            i_wbRegWrData   = randBits(32);
            predict();
            nextCycle();
            written = i_wbRegWrAddr;
            clearStages();                  // Read back with no forwarding
            i_inst = encodeFields(7'd0, RegAddr'(randBits(5)), written, 3'b000, 5'd1, OPC_OP);
            predict();
        end
        for (int t = 0; t < RAND_TRIALS; t++) begin
            nextCycle();
            randomCycle();
            predict();
        end
        nextCycle();
        $display("Run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((TEST_CYCLES + 20) * 100);
        $display("Timeout: the test sequence did not finish in the expected time");
        $display("Some tests failed");
        $finish;
    end

endmodule
